// ==== hw/decodePkg.sv ====
// Decode stage shared definitions
package decodePkg;

	// ==================================================
	// Sizes
	// ==================================================
	localparam int LANES = 4;
	localparam int INST_BITS = 36;
	localparam int INST_STRIDE = 5;
	localparam int ADDR_BITS = 32;
	localparam int VALUE_BITS = 64;
	localparam int REG_BITS = 6;
	localparam int LINK_BITS = 2;
	// Wide enough to hold a count of 0 to LANES
	localparam int COUNT_BITS = $clog2(LANES + 1);

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [REG_BITS-1:0] regNum_t;

	localparam regNum_t SP_REG = regNum_t'(30);

	// ==================================================
	// Opcodes and function codes
	// ==================================================
	typedef enum logic [7:0] {
		BRK = 8'h00, NOP = 8'h01, R1 = 8'h02, R2 = 8'h03, R3 = 8'h04,
		ADDI = 8'h08, SUBFI = 8'h09, ANDI = 8'h0A, ORI = 8'h0B, XORI = 8'h0C,
		MULI = 8'h10, MULUI = 8'h11, MULSUI = 8'h12,
		DIVI = 8'h13, DIVUI = 8'h14, DIVSUI = 8'h15,
		SEQI = 8'h18, SNEI = 8'h19, SLTI = 8'h1A, SGTI = 8'h1B,
		SLTUI = 8'h1C, SGTUI = 8'h1D,
		JAL = 8'h40, JALR = 8'h41, CALL = 8'h42, RTS = 8'h43,
		// Conditional branches share the 0x48 to 0x4F block
		BEQ = 8'h48, BNE = 8'h49, BLT = 8'h4A, BGE = 8'h4B,
		BLTU = 8'h4C, BGEU = 8'h4D, BBS = 8'h4E,
		LDx = 8'h60, LDxX = 8'h61, STx = 8'h70, STxX = 8'h71
	} opcode_e;

	// One value space for R1, R2 and R3 so that no two names share a code
	typedef enum logic [5:0] {
		ABS = 6'h00, NABS = 6'h01, NOT = 6'h02, CTLZ = 6'h03, CTPOP = 6'h04,
		ADD = 6'h08, SUB = 6'h09, AND = 6'h0A, OR = 6'h0B, XOR = 6'h0C,
		NAND = 6'h0D, NOR = 6'h0E, XNOR = 6'h0F, DIF = 6'h10, MULF = 6'h11,
		MUL = 6'h12, MULU = 6'h13, MULSU = 6'h14,
		MULH = 6'h15, MULUH = 6'h16, MULSUH = 6'h17,
		DIV = 6'h18, DIVU = 6'h19, DIVSU = 6'h1A,
		SLL = 6'h20, SRL = 6'h21, SLLI = 6'h22, SRLI = 6'h23,
		SEQ = 6'h28, SNE = 6'h29, SLT = 6'h2A, SGE = 6'h2B,
		CMP = 6'h2C, SLTU = 6'h2D, SGEU = 6'h2E,
		PTRDIF = 6'h30, SLLP = 6'h31, CHK = 6'h32
	} func_e;

	// ==================================================
	// Instruction formats
	// ==================================================
	typedef struct packed {
		logic [5:0] func;
		logic [3:0] spare;
		regNum_t Rb;
		regNum_t Ra;
		regNum_t Rt;
		logic [7:0] opcode;
	} rForm_t;

	typedef struct packed {
		logic [15:0] imm16;
		regNum_t Ra;
		regNum_t Rt;
		logic [7:0] opcode;
	} iForm_t;

	typedef struct packed {
		logic [3:0] spare;
		logic [11:0] disp12;
		regNum_t Ra;
		regNum_t Rt;
		logic [7:0] opcode;
	} ldForm_t;

	typedef union packed {
		logic [INST_BITS-1:0] raw;
		rForm_t r;
		iForm_t i;
		ldForm_t ld;
	} inst_t;

	// ==================================================
	// Pipeline payloads
	// ==================================================
	typedef struct packed {
		inst_t inst;
		addr_t ip;
	} fetchSlot_t;

	typedef fetchSlot_t [LANES-1:0] fetchBundle_t;

	typedef struct packed {
		logic ui;
		logic rfwr;
		logic needRa;
		logic needRb;
		logic isSigned;
		logic branch;
		logic call;
		logic memOp;
		logic mc;
		regNum_t Ra;
		regNum_t Rb;
		regNum_t Rt;
		logic [VALUE_BITS-1:0] imm;
		addr_t ip;
	} decoded_t;

	typedef struct packed {
		decoded_t [LANES-1:0] lane;
		logic [LANES-1:0] laneValid;
		logic [COUNT_BITS-1:0] rfwrCount;
	} decodedBundle_t;

endpackage

// ==== hw/fetchBundleSplit.sv ====
// Fetch bundle splitter
`timescale 1ns/1ps

module fetchBundleSplit import decodePkg::*; (
	input  logic              clk,
	input  logic              arstN,
	input  logic              bundleValid,
	input  inst_t [LANES-1:0] bundleInst,
	input  addr_t             bundleIp,
	output logic              slotValid,
	output fetchBundle_t      slots
);

	fetchBundle_t slotsNext;

	// Every slot sits a fixed stride after the one before it
	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			slotsNext[k].inst = bundleInst[k];
			slotsNext[k].ip = bundleIp + addr_t'(k * INST_STRIDE);
		end
	end

	// ==================================================
	// Bundle register
	// ==================================================
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			slotValid <= 1'b0;
		end else begin
			slotValid <= bundleValid;
		end
	end

	// Slots only load with a new bundle and hold otherwise
	always_ff @(posedge clk) begin
		if (bundleValid) begin
			slots <= slotsNext;
		end
	end

endmodule

// ==== hw/instDecode.sv ====
// Single instruction decoder
`timescale 1ns/1ps

module instDecode import decodePkg::*; (
	input  fetchSlot_t slot,
	output decoded_t   dec
);

	inst_t ir;
	logic [VALUE_BITS-1:0] immSext16;
	logic [VALUE_BITS-1:0] immZext16;
	logic [VALUE_BITS-1:0] immOnes16;
	logic [VALUE_BITS-1:0] immJump;
	logic [VALUE_BITS-1:0] immBranch;
	logic [VALUE_BITS-1:0] immLoad;
	logic [VALUE_BITS-1:0] immStore;

	assign ir = slot.inst;

	// ==================================================
	// Immediate forms
	// ==================================================
	assign immSext16 = {{(VALUE_BITS-16){ir.i.imm16[15]}}, ir.i.imm16};
	assign immZext16 = {{(VALUE_BITS-16){1'b0}}, ir.i.imm16};
	assign immOnes16 = {{(VALUE_BITS-16){1'b1}}, ir.i.imm16};
	assign immJump = {{(VALUE_BITS-26){ir.raw[35]}}, ir.raw[35:10]};
	// Branch displacement takes the Rt field as its low bits
	assign immBranch = {{(VALUE_BITS-16){ir.raw[35]}}, ir.raw[35:26], ir.r.Rt};
	assign immLoad = {{(VALUE_BITS-12){ir.ld.disp12[11]}}, ir.ld.disp12};
	assign immStore = {{(VALUE_BITS-12){ir.r.func[5]}}, ir.r.func, ir.r.Rt};

	// ==================================================
	// Decode table
	// ==================================================
	always_comb begin
		dec = '0;
		dec.ui = 1'b1;
		dec.needRa = 1'b1;
		dec.isSigned = 1'b1;
		dec.Ra = ir.r.Ra;
		dec.Rb = ir.r.Rb;
		dec.ip = slot.ip;

		case (ir.r.opcode)
		BRK, NOP: dec.ui = 1'b0;
		R1: begin
			case (ir.r.func)
			ABS, NABS, NOT, CTLZ, CTPOP: begin
				dec.ui = 1'b0;
				dec.rfwr = 1'b1;
				dec.Rt = ir.r.Rt;
			end
			default: ;
			endcase
		end
		R2: begin
			case (ir.r.func)
			ADD, SUB, AND, OR, XOR, NAND, NOR, XNOR, DIF, SLL, SRL,
			SEQ, SNE, SLT, SGE, CMP, MULF, SLTU, SGEU,
			MUL, MULU, MULSU, MULH, MULUH, MULSUH, DIV, DIVU, DIVSU,
			SLLI, SRLI: begin
				dec.ui = 1'b0;
				dec.rfwr = 1'b1;
				dec.needRb = 1'b1;
				dec.Rt = ir.r.Rt;
			end
			default: ;
			endcase
			case (ir.r.func)
			MULF, SLTU, SGEU: dec.isSigned = 1'b0;
			MUL, MULU, MULSU, MULH, MULUH, MULSUH, DIV, DIVU, DIVSU: dec.mc = 1'b1;
			SLLI, SRLI: dec.imm = {{(VALUE_BITS-REG_BITS){1'b0}}, ir.r.Rb};
			default: ;
			endcase
		end
		R3: begin
			case (ir.r.func)
			PTRDIF, SLLP: begin
				dec.ui = 1'b0;
				dec.rfwr = 1'b1;
				dec.needRb = 1'b1;
				dec.Rt = ir.r.Rt;
				dec.isSigned = (ir.r.func != PTRDIF);
			end
			// Bounds check reads only and writes nothing back
			CHK: begin
				dec.ui = 1'b0;
				dec.needRb = 1'b1;
			end
			default: ;
			endcase
		end
		ADDI, SUBFI, ANDI, ORI, XORI, MULI, MULUI, MULSUI, DIVI, DIVUI, DIVSUI,
		SEQI, SNEI, SLTI, SGTI, SLTUI, SGTUI: begin
			dec.ui = 1'b0;
			dec.rfwr = 1'b1;
			dec.Rt = ir.i.Rt;
			case (ir.i.opcode)
			ANDI: dec.imm = immOnes16;
			ORI, XORI, SLTUI, SGTUI, MULUI, MULSUI, DIVUI, DIVSUI: dec.imm = immZext16;
			default: dec.imm = immSext16;
			endcase
			case (ir.i.opcode)
			MULI, MULUI, MULSUI, DIVI, DIVUI, DIVSUI: dec.mc = 1'b1;
			default: ;
			endcase
			case (ir.i.opcode)
			SLTUI, SGTUI, MULUI, MULSUI, DIVSUI: dec.isSigned = 1'b0;
			default: ;
			endcase
		end
		JAL, JALR: begin
			dec.ui = 1'b0;
			dec.rfwr = 1'b1;
			dec.mc = 1'b1;
			dec.Rt = regNum_t'(ir.r.Rt[LINK_BITS-1:0]);
			// Only the register form reads a base register
			dec.needRa = (ir.r.opcode == JALR);
			dec.imm = (ir.r.opcode == JALR) ? immSext16 : immJump;
		end
		CALL, RTS: begin
			dec.ui = 1'b0;
			dec.rfwr = 1'b1;
			dec.mc = 1'b1;
			dec.call = (ir.r.opcode == CALL);
			dec.Rt = SP_REG;
			dec.Ra = SP_REG;
			dec.imm = (ir.r.opcode == CALL) ? immJump : immSext16;
		end
		BEQ, BNE, BLT, BGE, BLTU, BGEU, BBS: begin
			dec.ui = 1'b0;
			dec.branch = 1'b1;
			dec.needRb = 1'b1;
			dec.mc = 1'b1;
			dec.Ra[REG_BITS-1] = 1'b0;
			dec.imm = immBranch;
			dec.isSigned = !(ir.r.opcode inside {BLTU, BGEU, BBS});
		end
		LDx, LDxX: begin
			dec.ui = 1'b0;
			dec.rfwr = 1'b1;
			dec.memOp = 1'b1;
			dec.mc = 1'b1;
			dec.Rt = ir.ld.Rt;
			dec.needRb = (ir.ld.opcode == LDxX);
			dec.imm = (ir.ld.opcode == LDx) ? immLoad : '0;
		end
		STx, STxX: begin
			dec.ui = 1'b0;
			dec.memOp = 1'b1;
			dec.mc = 1'b1;
			dec.needRb = 1'b1;
			dec.imm = (ir.r.opcode == STx) ? immStore : '0;
		end
		default: ;
		endcase
	end

endmodule

// ==== hw/decodeCollect.sv ====
// Decoded bundle collector
`timescale 1ns/1ps

module decodeCollect import decodePkg::*; (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 slotValid,
	input  decoded_t [LANES-1:0] lanes,
	output logic                 decValid,
	output decodedBundle_t       decOut
);

	logic chainOk;
	logic [LANES-1:0] validMask;
	logic [COUNT_BITS-1:0] writeCount;
	logic [LANES-1:0] laneValidQ;
	logic [COUNT_BITS-1:0] rfwrCountQ;
	decoded_t [LANES-1:0] lanesQ;

	// ==================================================
	// Bundle cut and write count
	// ==================================================
	always_comb begin
		chainOk = 1'b1;
		validMask = '0;
		writeCount = '0;
		for (int k = 0; k < LANES; k++) begin
			// The first unimplemented lane ends the bundle
			chainOk = chainOk && !lanes[k].ui;
			validMask[k] = chainOk;
			if (chainOk && lanes[k].rfwr) begin
				writeCount = writeCount + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
			laneValidQ <= '0;
			rfwrCountQ <= '0;
		end else begin
			decValid <= slotValid;
			if (slotValid) begin
				laneValidQ <= validMask;
				rfwrCountQ <= writeCount;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (slotValid) begin
			lanesQ <= lanes;
		end
	end

	assign decOut = '{lane: lanesQ, laneValid: laneValidQ, rfwrCount: rfwrCountQ};

	// Valid lanes form one run starting at lane 0
	laneValidContiguous: assert property (@(posedge clk) disable iff (!arstN)
		decValid |-> (decOut.laneValid & (decOut.laneValid + 1'b1)) == '0);

	rfwrCountBounded: assert property (@(posedge clk) disable iff (!arstN)
		decValid |-> decOut.rfwrCount <= $countones(decOut.laneValid));

endmodule

// ==== hw/decodeStage.sv ====
// Multi-lane decode stage
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
	input  logic              clk,
	input  logic              arstN,
	input  logic              bundleValid,
	input  inst_t [LANES-1:0] bundleInst,
	input  addr_t             bundleIp,
	output logic              decValid,
	output decodedBundle_t    decOut
);

	logic slotValid;
	fetchBundle_t slots;
	decoded_t [LANES-1:0] laneDec;

	fetchBundleSplit fetchBundleSplit_i (
		.clk(clk),
		.arstN(arstN),
		.bundleValid(bundleValid),
		.bundleInst(bundleInst),
		.bundleIp(bundleIp),
		.slotValid(slotValid),
		.slots(slots)
	);

	for (genvar g = 0; g < LANES; g++) begin : laneGen
		instDecode instDecode_i (
			.slot(slots[g]),
			.dec(laneDec[g])
		);
	end

	decodeCollect decodeCollect_i (
		.clk(clk),
		.arstN(arstN),
		.slotValid(slotValid),
		.lanes(laneDec),
		.decValid(decValid),
		.decOut(decOut)
	);

endmodule

// ==== testbench/decodeModel.svh ====
// Reference decode model
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic logic [63:0] signExtend(logic [63:0] v, int width);
	logic [63:0] upper;
	upper = {64{1'b1}} << width;
	return v[width-1] ? (v | upper) : (v & ~upper);
endfunction

function automatic bit isKeptOp(logic [7:0] op);
	return op inside {BRK, NOP, R1, R2, R3, ADDI, SUBFI, ANDI, ORI, XORI,
		MULI, MULUI, MULSUI, DIVI, DIVUI, DIVSUI, SEQI, SNEI, SLTI, SGTI, SLTUI, SGTUI,
		JAL, JALR, CALL, RTS, BEQ, BNE, BLT, BGE, BLTU, BGEU, BBS, LDx, LDxX, STx, STxX};
endfunction

// Function codes only matter for the three register forms
function automatic bit isKeptFunc(logic [7:0] op, logic [5:0] fn);
	case (op)
	R1: return fn inside {ABS, NABS, NOT, CTLZ, CTPOP};
	R2: return fn inside {ADD, SUB, AND, OR, XOR, NAND, NOR, XNOR, DIF, MULF,
		MUL, MULU, MULSU, MULH, MULUH, MULSUH, DIV, DIVU, DIVSU,
		SLL, SRL, SLLI, SRLI, SEQ, SNE, SLT, SGE, CMP, SLTU, SGEU};
	R3: return fn inside {PTRDIF, SLLP, CHK};
	default: return 1'b1;
	endcase
endfunction

function automatic decoded_t modelDecode(logic [35:0] raw, addr_t ip);
	decoded_t d;
	logic [7:0] op;
	logic [5:0] fn;
	logic [5:0] rt;
	op = raw[7:0];
	fn = raw[35:30];
	rt = raw[13:8];
	d = '0;
	d.ui = !(isKeptOp(op) && isKeptFunc(op, fn));
	d.needRa = 1'b1;
	d.isSigned = 1'b1;
	d.Ra = raw[19:14];
	d.Rb = raw[25:20];
	d.ip = ip;
	if (d.ui) begin
		return d;
	end
	case (op)
	R1, R2, R3: begin
		d.needRb = (op != R1);
		d.rfwr = (fn != CHK);
		d.Rt = d.rfwr ? rt : 6'd0;
		d.isSigned = !(fn inside {MULF, SLTU, SGEU, PTRDIF});
		d.mc = fn inside {MUL, MULU, MULSU, MULH, MULUH, MULSUH, DIV, DIVU, DIVSU};
		if (fn inside {SLLI, SRLI}) begin
			d.imm = 64'(raw[25:20]);
		end
	end
	ADDI, SUBFI, ANDI, ORI, XORI, MULI, MULUI, MULSUI, DIVI, DIVUI, DIVSUI,
	SEQI, SNEI, SLTI, SGTI, SLTUI, SGTUI: begin
		d.rfwr = 1'b1;
		d.Rt = rt;
		if (op == ANDI) begin
			d.imm = {48'hFFFF_FFFF_FFFF, raw[35:20]};
		end else if (op inside {ORI, XORI, SLTUI, SGTUI, MULUI, MULSUI, DIVUI, DIVSUI}) begin
			d.imm = 64'(raw[35:20]);
		end else begin
			d.imm = signExtend(raw[35:20], 16);
		end
		d.mc = op inside {MULI, MULUI, MULSUI, DIVI, DIVUI, DIVSUI};
		d.isSigned = !(op inside {SLTUI, SGTUI, MULUI, MULSUI, DIVSUI});
	end
	JAL, JALR: begin
		d.rfwr = 1'b1;
		d.mc = 1'b1;
		d.Rt = {4'b0, rt[1:0]};
		d.needRa = (op == JALR);
		d.imm = (op == JALR) ? signExtend(raw[35:20], 16) : signExtend(raw[35:10], 26);
	end
	CALL, RTS: begin
		d.rfwr = 1'b1;
		d.mc = 1'b1;
		d.call = (op == CALL);
		d.Rt = 6'd30;
		d.Ra = 6'd30;
		d.imm = (op == CALL) ? signExtend(raw[35:10], 26) : signExtend(raw[35:20], 16);
	end
	BEQ, BNE, BLT, BGE, BLTU, BGEU, BBS: begin
		d.branch = 1'b1;
		d.needRb = 1'b1;
		d.mc = 1'b1;
		d.Ra[5] = 1'b0;
		d.imm = signExtend({raw[35:26], rt}, 16);
		d.isSigned = !(op inside {BLTU, BGEU, BBS});
	end
	LDx, LDxX: begin
		d.rfwr = 1'b1;
		d.memOp = 1'b1;
		d.mc = 1'b1;
		d.Rt = rt;
		d.needRb = (op == LDxX);
		d.imm = (op == LDx) ? signExtend(raw[31:20], 12) : 64'd0;
	end
	STx, STxX: begin
		d.memOp = 1'b1;
		d.mc = 1'b1;
		d.needRb = 1'b1;
		d.imm = (op == STx) ? signExtend({fn, rt}, 12) : 64'd0;
	end
	default: ;
	endcase
	return d;
endfunction

// Whole bundle: lanes before the first unimplemented one are valid
function automatic decodedBundle_t modelBundle(logic [LANES-1:0][35:0] insts, addr_t ip);
	decodedBundle_t b;
	int firstBad;
	b = '0;
	firstBad = LANES;
	for (int k = LANES - 1; k >= 0; k--) begin
		b.lane[k] = modelDecode(insts[k], ip + addr_t'(k * INST_STRIDE));
		if (b.lane[k].ui) begin
			firstBad = k;
		end
	end
	for (int k = 0; k < firstBad; k++) begin
		b.laneValid[k] = 1'b1;
		b.rfwrCount = b.rfwrCount + b.lane[k].rfwr;
	end
	return b;
endfunction

`endif

// ==== testbench/decodeStageTb.sv ====
// Decode stage testbench
`timescale 1ns/1ps

module decodeStageTb import decodePkg::*; ();

	`include "decodeModel.svh"

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int LATENCY = 2;
	localparam int DRAIN_LIMIT = 50;

	logic clk;
	logic arstN;
	logic bundleValid;
	inst_t [LANES-1:0] bundleInst;
	addr_t bundleIp;
	logic decValid;
	decodedBundle_t decOut;

	decodedBundle_t expQ[$];
	int issueQ[$];
	int edgeCount = 0;
	int errCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	decodeStage decodeStage_i (
		.clk(clk),
		.arstN(arstN),
		.bundleValid(bundleValid),
		.bundleInst(bundleInst),
		.bundleIp(bundleIp),
		.decValid(decValid),
		.decOut(decOut)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		edgeCount <= edgeCount + 1;
	end

	// ==================================================
	// Checking helpers
	// ==================================================
	task automatic checkValue(string what, int lane, logic [63:0] got, logic [63:0] exp);
		assert (got === exp) else begin
			$display("ERR @%0t: lane %0d %s is %0h, expected %0h", $time, lane, what, got, exp);
			errCount++;
		end
	endtask

	task automatic compareBundle(decodedBundle_t got, decodedBundle_t exp);
		checkValue("laneValid", -1, got.laneValid, exp.laneValid);
		checkValue("rfwrCount", -1, got.rfwrCount, exp.rfwrCount);
		for (int k = 0; k < LANES; k++) begin
			checkValue("ui", k, got.lane[k].ui, exp.lane[k].ui);
			checkValue("rfwr", k, got.lane[k].rfwr, exp.lane[k].rfwr);
			checkValue("needRa", k, got.lane[k].needRa, exp.lane[k].needRa);
			checkValue("needRb", k, got.lane[k].needRb, exp.lane[k].needRb);
			checkValue("isSigned", k, got.lane[k].isSigned, exp.lane[k].isSigned);
			checkValue("branch", k, got.lane[k].branch, exp.lane[k].branch);
			checkValue("call", k, got.lane[k].call, exp.lane[k].call);
			checkValue("memOp", k, got.lane[k].memOp, exp.lane[k].memOp);
			checkValue("mc", k, got.lane[k].mc, exp.lane[k].mc);
			checkValue("Ra", k, got.lane[k].Ra, exp.lane[k].Ra);
			checkValue("Rb", k, got.lane[k].Rb, exp.lane[k].Rb);
			checkValue("Rt", k, got.lane[k].Rt, exp.lane[k].Rt);
			checkValue("imm", k, got.lane[k].imm, exp.lane[k].imm);
			checkValue("ip", k, got.lane[k].ip, exp.lane[k].ip);
		end
	endtask

	// Outputs are sampled half a cycle after the edge that updates them
	always @(negedge clk) begin : outputMonitor
		decodedBundle_t exp;
		int issue;
		if (arstN && decValid) begin
			if (expQ.size() == 0) begin
				$display("Unexpected decValid at %0t with no bundle pending", $time);
				errCount++;
			end else begin
				exp = expQ.pop_front();
				issue = issueQ.pop_front();
				checkValue("latency", -1, edgeCount - issue, LATENCY);
				compareBundle(decOut, exp);
			end
		end
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================
	function automatic logic [35:0] randomLane(int unimplPct);
		logic [35:0] raw;
		raw = 36'({$urandom(), $urandom()});
		if ($urandom_range(99) < unimplPct) begin
			// Some lanes take a register form with a function code outside the kept set
			if ($urandom_range(3) == 0) begin
				raw[7:0] = 8'(R1) + 8'($urandom_range(2));
				while (isKeptFunc(raw[7:0], raw[35:30])) begin
					raw[35:30] = 6'($urandom());
				end
			end else begin
				while (isKeptOp(raw[7:0])) begin
					raw[7:0] = 8'($urandom());
				end
			end
		end else begin
			while (!isKeptOp(raw[7:0])) begin
				raw[7:0] = 8'($urandom());
			end
			while (!isKeptFunc(raw[7:0], raw[35:30])) begin
				raw[35:30] = 6'($urandom());
			end
		end
		return raw;
	endfunction

	function automatic logic [LANES-1:0][35:0] randomBundle(int unimplPct);
		logic [LANES-1:0][35:0] insts;
		for (int k = 0; k < LANES; k++) begin
			insts[k] = randomLane(unimplPct);
		end
		return insts;
	endfunction

	function automatic logic [35:0] buildInst(logic [7:0] op, logic [5:0] rt, logic [5:0] ra,
		logic [15:0] upper);
		return {upper, ra, rt, op};
	endfunction

	function automatic logic [35:0] buildReg(logic [7:0] op, logic [5:0] fn, logic [5:0] rt,
		logic [5:0] ra, logic [5:0] rb);
		return {fn, 4'h0, rb, ra, rt, op};
	endfunction

	task automatic sendBundle(logic [LANES-1:0][35:0] insts);
		addr_t ip;
		ip = $urandom();
		@(posedge clk);
		bundleValid <= 1'b1;
		bundleInst <= insts;
		bundleIp <= ip;
		expQ.push_back(modelBundle(insts, ip));
		issueQ.push_back(edgeCount + 1);
	endtask

	task automatic idleCycles(int n);
		repeat (n) begin
			@(posedge clk);
			bundleValid <= 1'b0;
		end
	endtask

	task automatic drainResults(string name);
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("Timeout in %s: %0d results never arrived", name, expQ.size());
			errCount++;
			expQ.delete();
			issueQ.delete();
		end
	endtask

	task automatic reportTest(string name, int bundles, int errBefore);
		testsRun++;
		if (errCount != errBefore) begin
			testsFailed++;
		end
		$display("test %-12s %4d bundles, %0d errors", name, bundles, errCount - errBefore);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int errBefore;
		void'($urandom(11));
		arstN = 1'b0;
		bundleValid = 1'b0;
		bundleInst = '0;
		bundleIp = '0;

		errBefore = errCount;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
		end
		arstN <= 1'b1;
		repeat (20) begin
			@(negedge clk);
			checkValue("decValid idle", -1, decValid, 1'b0);
			checkValue("laneValid idle", -1, decOut.laneValid, '0);
		end
		reportTest("resetIdle", 0, errBefore);

		// Strobes on every cycle keep two bundles in flight
		errBefore = errCount;
		repeat (300) begin
			sendBundle(randomBundle(15));
		end
		idleCycles(1);
		drainResults("backToBack");
		reportTest("backToBack", 300, errBefore);

		errBefore = errCount;
		repeat (200) begin
			sendBundle(randomBundle(0));
			idleCycles($urandom_range(2));
		end
		idleCycles(1);
		drainResults("keptDecode");
		reportTest("keptDecode", 200, errBefore);

		errBefore = errCount;
		repeat (150) begin
			sendBundle(randomBundle(35));
		end
		idleCycles(1);
		drainResults("unimplCut");
		reportTest("unimplCut", 150, errBefore);

		// Lane 0 is the rightmost entry of each bundle
		errBefore = errCount;
		sendBundle({buildInst(RTS, 6'h01, 6'h02, 16'h8000), buildInst(CALL, 6'h05, 6'h07, 16'h7FFF),
			buildInst(JALR, 6'h3E, 6'h11, 16'hFFFF), buildInst(JAL, 6'h3F, 6'h2A, 16'h8001)});
		sendBundle({buildInst(BLTU, 6'h12, 6'h3F, 16'h8040), buildInst(BGEU, 6'h3F, 6'h3F, 16'h0040),
			buildInst(BBS, 6'h00, 6'h3F, 16'hFFC0), buildInst(BEQ, 6'h21, 6'h3F, 16'h4000)});
		sendBundle({buildInst(BNE, 6'h0A, 6'h20, 16'h8000), buildInst(BLT, 6'h0B, 6'h21, 16'h0000),
			buildInst(BGE, 6'h0C, 6'h3A, 16'hC000), buildInst(BLTU, 6'h0D, 6'h2F, 16'h7FC0)});
		sendBundle({buildInst(SLTUI, 6'h03, 6'h04, 16'h8000), buildInst(SGTUI, 6'h05, 6'h06, 16'hFFFF),
			buildInst(MULUI, 6'h07, 6'h08, 16'h8001), buildInst(DIVSUI, 6'h09, 6'h0A, 16'h8000)});
		sendBundle({buildReg(R2, SLTU, 6'h05, 6'h06, 6'h07), buildReg(R2, SGEU, 6'h08, 6'h09, 6'h0A),
			buildReg(R2, MULF, 6'h0B, 6'h0C, 6'h0D), buildReg(R3, PTRDIF, 6'h0E, 6'h0F, 6'h10)});
		sendBundle({buildInst(MULSUI, 6'h11, 6'h12, 16'h9000), buildInst(DIVUI, 6'h13, 6'h14, 16'h8000),
			buildReg(R2, SLLI, 6'h15, 6'h16, 6'h3F), buildReg(STx, 6'h20, 6'h3F, 6'h17, 6'h18)});
		idleCycles(1);
		drainResults("specialCases");
		reportTest("specialCases", 6, errBefore);

		$display("Summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+testbench
hw/decodePkg.sv
hw/fetchBundleSplit.sv
hw/instDecode.sv
hw/decodeCollect.sv
hw/decodeStage.sv
testbench/decodeStageTb.sv

// ==== Bender.yml ====
package:
  name: decodeStage

sources:
  - hw/decodePkg.sv
  - hw/fetchBundleSplit.sv
  - hw/instDecode.sv
  - hw/decodeCollect.sv
  - hw/decodeStage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/decodeStageTb.sv
